/* spi_mem_defs.svh */
`ifndef SPI_MEM_DEFS_SVH
`define SPI_MEM_DEFS_SVH

// --------------------------------------------------
// Memory geometry
// --------------------------------------------------
`define SPI_ADDR_W      7       // Upper seven bits of the command byte
`define SPI_DATA_W      8
`define SPI_MEM_DEPTH   128

// --------------------------------------------------
// Input conditioning
// --------------------------------------------------
// Cycles a new level must hold before it is accepted
`define SPI_DEBOUNCE    3

`endif

/* spi_mem_pkg.sv */
`default_nettype none

`include "spi_mem_defs.svh"

package spi_mem_pkg;

    typedef logic [`SPI_ADDR_W-1:0] spi_addr_t;
    typedef logic [`SPI_DATA_W-1:0] spi_data_t;
    typedef logic [2:0]             bit_cnt_t;   // Bit position within a byte

    typedef enum logic [2:0] {
        idle,
        get_addr,       // Shifting in the command byte
        decide,         // Waiting for the direction bit
        write_data,
        do_write,
        read_load,
        read_shift,
        done            // Byte finished until cs_n rises
    } spi_state_t;

endpackage

`default_nettype wire

/* spi_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface spi_ctrl_if;

    logic addr_we;  // Latch address and direction
    logic sr_load;  // Parallel load from memory
    logic mem_we;
    logic miso_en;  // High while read data goes out
    logic is_read;

    modport ctrl (
        output addr_we, sr_load, mem_we, miso_en,
        input  is_read
    );

    modport dp (
        input  addr_we, sr_load, mem_we, miso_en,
        output is_read
    );

endinterface

`default_nettype wire

/* input_conditioner.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_mem_defs.svh"

module input_conditioner (
    input  logic clk,
    input  logic rst_n,
    input  logic noisy,
    output logic clean,
    output logic rise,
    output logic fall
);

    localparam int CNT_W = $clog2(`SPI_DEBOUNCE + 1);

    logic [1:0]       sync_q;
    logic [CNT_W-1:0] cnt_q;

    // --------------------------------------------------
    // Two-flop synchronizer
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= 2'b11;    // Match the idle-high reset of clean
        end else begin
            sync_q <= {sync_q[0], noisy};
        end
    end

    // --------------------------------------------------
    // Glitch filter and edge pulses
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clean <= 1'b1;
            cnt_q <= '0;
            rise  <= 1'b0;
            fall  <= 1'b0;
        end else begin
            rise <= 1'b0;
            fall <= 1'b0;
            if (sync_q[1] == clean) begin
                cnt_q <= '0;    // Input bounced back
            end else if (cnt_q == CNT_W'(`SPI_DEBOUNCE - 1)) begin
                clean <= sync_q[1];
                cnt_q <= '0;
                rise  <= sync_q[1];
                fall  <= ~sync_q[1];
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* spi_data_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_mem_defs.svh"

module spi_data_mem import spi_mem_pkg::*; (
    input  logic      clk,
    input  spi_addr_t addr,
    input  spi_data_t wdata,
    input  logic      we,
    output spi_data_t rdata
);

    spi_data_t mem [`SPI_MEM_DEPTH];

    // Write and registered read share the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];     // Old data on a same-cycle write
    end

endmodule

`default_nettype wire

/* spi_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_datapath import spi_mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sclk_rise,
    input  logic      sclk_fall,
    input  logic      mosi,
    input  spi_data_t mem_rdata,
    output spi_data_t sr_data,
    output spi_addr_t addr,
    output logic      miso,
    spi_ctrl_if.dp    ctrl
);

    localparam int MSB = $bits(spi_data_t) - 1;

    spi_data_t shift_q;
    logic      miso_q;

    // --------------------------------------------------
    // Shift register with priority load
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl.sr_load) begin
            shift_q <= mem_rdata;
        end else if (sclk_rise) begin
            shift_q <= {shift_q[MSB-1:0], mosi};    // MSB first in
        end
    end

    assign sr_data = shift_q;

    // Address and direction from the command byte
    always_ff @(posedge clk) begin
        if (ctrl.addr_we) begin
            addr <= shift_q[MSB:1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.is_read <= 1'b0;
        end else if (ctrl.addr_we) begin
            ctrl.is_read <= shift_q[0];
        end
    end

    // --------------------------------------------------
    // miso register updated on sclk falling edges
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miso_q <= 1'b0;
        end else if (sclk_fall) begin
            miso_q <= shift_q[MSB];
        end
    end

    assign miso = miso_q & ctrl.miso_en;    // Held low outside read data

endmodule

`default_nettype wire

/* spi_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_fsm import spi_mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    sclk_rise,
    input  logic    sclk_fall,
    input  logic    cs_fall,
    input  logic    cs_rise,
    spi_ctrl_if.ctrl ctrl
);

    spi_state_t state;
    bit_cnt_t   bit_cnt;

    // --------------------------------------------------
    // State register and registered strobes
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= idle;
            bit_cnt      <= '0;
            ctrl.addr_we <= 1'b0;
            ctrl.sr_load <= 1'b0;
            ctrl.mem_we  <= 1'b0;
            ctrl.miso_en <= 1'b0;
        end else begin
            // Strobes default to a single cycle
            ctrl.addr_we <= 1'b0;
            ctrl.sr_load <= 1'b0;
            ctrl.mem_we  <= 1'b0;

            if (cs_rise) begin
                state        <= idle;   // Abort without a write
                bit_cnt      <= '0;
                ctrl.miso_en <= 1'b0;
            end else begin
                case (state)
                    idle: begin
                        if (cs_fall) begin
                            state   <= get_addr;
                            bit_cnt <= '0;
                        end
                    end
                    get_addr: begin
                        if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;  // Wraps to 0 after bit 7
                            if (bit_cnt == 3'd7) begin
                                state        <= decide;
                                ctrl.addr_we <= 1'b1;
                            end
                        end
                    end
                    decide: begin
                        // is_read is valid once the addr_we cycle is over
                        if (!ctrl.addr_we) begin
                            if (ctrl.is_read) begin
                                state        <= read_load;
                                ctrl.sr_load <= 1'b1;
                            end else begin
                                state <= write_data;
                            end
                        end
                    end
                    write_data: begin
                        if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state       <= do_write;
                                ctrl.mem_we <= 1'b1;
                            end
                        end
                    end
                    do_write: state <= done;
                    read_load: begin
                        // Last fall of the command byte puts out the data MSB
                        if (sclk_fall) begin
                            state        <= read_shift;
                            ctrl.miso_en <= 1'b1;
                        end
                    end
                    read_shift: begin
                        if (sclk_fall) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state        <= done;
                                ctrl.miso_en <= 1'b0;
                            end
                        end
                    end
                    done: state <= done;        // Until cs_n rises
                    default: state <= idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* spi_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_mem import spi_mem_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso
);

    logic      sclk_rise, sclk_fall;
    logic      cs_rise, cs_fall;
    logic      mosi_sync;
    spi_data_t mem_rdata;
    spi_data_t sr_data;
    spi_addr_t addr;

    spi_ctrl_if ctrl_if ();

    // --------------------------------------------------
    // Input conditioning
    // --------------------------------------------------
    input_conditioner i_sclk_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .noisy (sclk),
        .clean (),
        .rise  (sclk_rise),
        .fall  (sclk_fall)
    );

    input_conditioner i_cs_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .noisy (cs_n),
        .clean (),
        .rise  (cs_rise),
        .fall  (cs_fall)
    );

    input_conditioner i_mosi_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .noisy (mosi),
        .clean (mosi_sync),
        .rise  (),
        .fall  ()
    );

    // --------------------------------------------------
    // Control, datapath and storage
    // --------------------------------------------------
    spi_fsm i_spi_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .cs_fall   (cs_fall),
        .cs_rise   (cs_rise),
        .ctrl      (ctrl_if.ctrl)
    );

    spi_datapath i_spi_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .mosi      (mosi_sync),
        .mem_rdata (mem_rdata),
        .sr_data   (sr_data),
        .addr      (addr),
        .miso      (miso),
        .ctrl      (ctrl_if.dp)
    );

    spi_data_mem i_spi_data_mem (
        .clk   (clk),
        .addr  (addr),
        .wdata (sr_data),   // Shift register is the write data
        .we    (ctrl_if.mem_we),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* spi_mem_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_mem_assertions import spi_mem_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       cs_fall,
    input logic       cs_rise,
    input spi_state_t state,
    input logic       addr_we,
    input logic       sr_load,
    input logic       mem_we,
    input logic       miso_en
);

    int unsigned fail_count = 0;
    logic        cs_high;       // Chip select level as the FSM sees it

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cs_high <= 1'b1;
        end else if (cs_rise) begin
            cs_high <= 1'b1;
        end else if (cs_fall) begin
            cs_high <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Strobe rules
    // --------------------------------------------------
    no_load_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_we && sr_load)) else begin
        $error("mem_we and sr_load high in the same cycle");
        fail_count++;
    end

    no_miso_en_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == idle) |-> !miso_en) else begin
        $error("miso_en high in idle");
        fail_count++;
    end

    quiet_deselected: assert property (@(posedge clk) disable iff (!rst_n)
        cs_high |-> !(addr_we || sr_load || mem_we || miso_en)) else begin
        $error("Strobe active while cs_n is high");
        fail_count++;
    end

    addr_we_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        addr_we |=> !addr_we) else begin
        $error("addr_we longer than one cycle");
        fail_count++;
    end

endmodule

bind spi_fsm spi_mem_assertions i_fsm_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .cs_fall (cs_fall),
    .cs_rise (cs_rise),
    .state   (state),
    .addr_we (ctrl.addr_we),
    .sr_load (ctrl.sr_load),
    .mem_we  (ctrl.mem_we),
    .miso_en (ctrl.miso_en)
);

`default_nettype wire

/* spi_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spi_mem_defs.svh"

module spi_mem_tb import spi_mem_pkg::*; ();

    localparam int HALF       = 10;     // clk cycles per sclk half-period
    localparam int MAX_CYCLES = 20000;
    localparam int MAX_LINES  = 64;

    logic      clk, rst_n, sclk, cs_n, mosi, miso;
    logic      quiet;                   // miso must read 0
    integer    seed;
    spi_data_t shadow  [`SPI_MEM_DEPTH];
    bit        written [`SPI_MEM_DEPTH];

    spi_mem i_spi_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .sclk  (sclk),
        .cs_n  (cs_n),
        .mosi  (mosi),
        .miso  (miso)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #5;     // Drive point after the edge
    endtask

    // --------------------------------------------------
    // SPI master, mode 0
    // --------------------------------------------------
    task automatic transfer_bit(input logic out_bit, input bit glitchy, output logic in_bit);
        int offset;
        int width;
        mosi = out_bit;
        if (glitchy && ($random(seed) & 1) == 1) begin
            offset = 2 + $unsigned($random(seed)) % 4;
            width  = 1 + $unsigned($random(seed)) % (`SPI_DEBOUNCE - 1);
            wait_clks(offset);
            sclk = 1'b1;    // Runt pulse for the glitch filter
            wait_clks(width);
            sclk = 1'b0;
            wait_clks(HALF - offset - width);
        end else begin
            wait_clks(HALF);
        end
        in_bit = miso;      // Sampled at the sclk rising edge
        sclk   = 1'b1;
        wait_clks(HALF);
        sclk   = 1'b0;
    endtask

    task automatic transfer_byte(input spi_data_t out_byte, input bit glitchy, input int nbits,
                                 output spi_data_t in_byte);
        spi_data_t tx;
        logic      b;
        tx      = out_byte;
        in_byte = '0;
        repeat (nbits) begin
            transfer_bit(tx[7], glitchy, b);
            tx      = {tx[6:0], 1'b0};
            in_byte = {in_byte[6:0], b};
        end
    endtask

    task automatic run_transaction(input logic [7:0] op, input spi_addr_t addr,
                                   input spi_data_t data, input bit glitchy);
        spi_data_t rx;
        cs_n = 1'b0;
        transfer_byte({addr, op == "R"}, glitchy, 8, rx);
        case (op)
            "W": begin
                transfer_byte(data, glitchy, 8, rx);
                shadow[addr]  = data;
                written[addr] = 1'b1;
            end
            "A": transfer_byte(data, glitchy, 4, rx);  // cs_n rises mid-byte
            "R": begin
                assert (written[addr] && shadow[addr] == data) else
                    report_failure($sformatf("Stimulus expects %h at address %h, shadow holds %h",
                                             data, addr, shadow[addr]));
                quiet = 1'b0;
                transfer_byte(8'h00, glitchy, 8, rx);
                assert (rx === data) else
                    report_failure($sformatf("[FAIL] %0t: read of address %h gave %h, expected %h",
                                             $time, addr, rx, data));
            end
            default: report_failure($sformatf("Unknown operation %c in the stimulus file", op));
        endcase
        wait_clks(HALF);
        cs_n  = 1'b1;
        quiet = 1'b1;
        wait_clks(2 * HALF);
    endtask

    always @(negedge clk) begin
        if (quiet) begin
            assert (miso === 1'b0) else
                report_failure($sformatf("[FAIL] %0t: miso is %b while it must be low",
                                         $time, miso));
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        report_failure($sformatf("Simulation did not finish within %0d clock cycles", MAX_CYCLES));
    end

    initial begin : main
        int         fd, n_fields, n_lines, n_trans, glitchy;
        string      line;
        logic [7:0] op;
        spi_addr_t  addr;
        spi_data_t  data;
        seed    = 32'h6df8ea0b;
        rst_n   = 1'b0;
        sclk    = 1'b0;
        cs_n    = 1'b1;
        mosi    = 1'b0;
        quiet   = 1'b0;
        n_lines = 0;
        n_trans = 0;
        wait_clks(8);
        rst_n = 1'b1;
        wait_clks(2 * HALF);    // Conditioners settle on idle levels
        quiet = 1'b1;
        fd = $fopen("spi_mem_stim.txt", "r");
        if (fd == 0) begin
            report_failure("Cannot open the stimulus file spi_mem_stim.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                n_lines++;
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n_fields = $sscanf(line, "%c %h %h %d", op, addr, data, glitchy);
                    assert (n_fields == 4) else
                        report_failure($sformatf("Malformed stimulus line: %s", line));
                    run_transaction(op, addr, data, glitchy != 0);
                    n_trans++;
                end
            end
            $fclose(fd);
            assert (n_trans > 0) else report_failure("No transactions found in the stimulus file");
            if (i_spi_mem.i_spi_fsm.i_fsm_assertions.fail_count == 0) begin
                $display("Done: no errors");
                $finish;
            end else begin
                report_failure("Concurrent assertions on the FSM failed");
            end
        end
    end

endmodule

`default_nettype wire

/* spi_mem_stim.txt */
# op addr data glitch (addr and data in hex, glitch 1 inserts runt sclk pulses)
# op W write, R read with data as the expected byte, A write aborted after four data bits
W 05 A5 0
R 05 A5 0
W 7F 3C 0
W 00 81 0
R 7F 3C 0
W 05 5A 0
R 05 5A 0
R 00 81 0
A 05 FF 0
R 05 5A 0
W 2A C3 1
R 2A C3 1
R 7F 3C 1
A 00 00 1
R 00 81 1

/* spi_mem.f */
+incdir+.
spi_mem_pkg.sv
spi_ctrl_if.sv
input_conditioner.sv
spi_data_mem.sv
spi_datapath.sv
spi_fsm.sv
spi_mem.sv
spi_mem_assertions.sv
spi_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f spi_mem.f \
    --top-module spi_mem_tb -o spi_mem_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/spi_mem_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
